// ==== tb/link_trace.txt ====
// Columns: link_up drain_hold cycles exp_tx_count exp_buffer_used (hex)
// FFFF in an expected column means that value is not checked
//
// Link down after reset, nothing may move
0 0 0014 0000 0000
//
// Link up with the switch held, all 16 VCs fill their 6 credits
1 1 012C 0060 0060
//
// Draining at one per 8 cycles, credits keep the injector busy
1 0 0190 FFFF FFFF
//
// Link lost, beats stop and the buffer empties
0 0 03E8 FFFF 0000
//
// Link back, startup wait then a fresh burst
1 0 00C8 FFFF FFFF
//
// Second link loss, buffer empties again
0 0 03E8 FFFF 0000

// ==== project.f ====
logic/fcp_pkg.sv
logic/link_startup_ctrl.sv
logic/switch_buffer_fifo.sv
logic/credit_injector.sv
logic/downstream_switch.sv
logic/flow_link_top.sv
tb/tb_clock_gen.sv
tb/flow_link_assertions.sv
tb/tb_flow_link.sv

// ==== Makefile ====
# Verilator build and run for the credit link testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_flow_link
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM_LOG   = sim.log
PASS_MSG  = TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the log, not the simulator exit code
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -qx "$(PASS_MSG)" $(SIM_LOG) || { echo "Simulation did not pass, see $(SIM_LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== tb/tb_flow_link.sv ====
// ==============================
// Testbench for the credit link.
// Replays segments from tb/link_trace.txt and checks beats,
// credit updates and debug counters against a credit model.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_flow_link;

    localparam int NUM_VC       = 16;
    localparam int QMAX         = 6;
    localparam int CNT_W        = 16;
    localparam int MAX_SEGS     = 32;
    localparam int SEG_WORDS    = 5;
    // Cycles from a link drop until beats must have stopped
    localparam int LINK_SLACK   = 5;
    localparam int TIMEOUT_PAD  = 200;
    localparam logic [15:0] NO_CHECK = 16'hFFFF;

    logic             sys_clk;
    logic             arst_n;
    logic             link_up;
    logic             drain_hold;
    logic             link_ready;
    logic             tx_valid;
    logic [3:0]       tx_vc;
    logic [CNT_W-1:0] tx_seq;
    logic [CNT_W-1:0] tx_count;
    logic             fcp_valid;
    logic [3:0]       fcp_vc;
    logic [CNT_W-1:0] fcp_fccl;
    logic [CNT_W-1:0] buffer_used;

    logic [15:0] trace_mem [MAX_SEGS*SEG_WORDS];
    int num_segs        = 0;
    int cycle_cnt       = 0;
    int cycle_limit     = 0;
    int link_low_cycles = 0;
    int total_beats     = 0;
    int beats_on_vc [NUM_VC] = '{default: 0};
    int fcps_on_vc  [NUM_VC] = '{default: 0};

    tb_clock_gen #(
        .PERIOD_NS   (8),
        .RESET_CYCLES(3)
    ) u_clock (
        .sys_clk(sys_clk),
        .arst_n (arst_n)
    );

    flow_link_top #(
        .QMAX(QMAX)
    ) UUT (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .link_up    (link_up),
        .drain_hold (drain_hold),
        .link_ready (link_ready),
        .tx_valid   (tx_valid),
        .tx_vc      (tx_vc),
        .tx_seq     (tx_seq),
        .tx_count   (tx_count),
        .fcp_valid  (fcp_valid),
        .fcp_vc     (fcp_vc),
        .fcp_fccl   (fcp_fccl),
        .buffer_used(buffer_used)
    );

    // ==============================
    // Failure reporting
    // ==============================
    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_problem(input string reason);
        $display("%s", reason);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // ==============================
    // Credit model and beat monitor
    // ==============================
    always @(negedge sys_clk) begin
        if (arst_n) begin
            if (!link_up) begin
                link_low_cycles++;
            end else begin
                link_low_cycles = 0;
            end
            if (link_low_cycles > LINK_SLACK) begin
                check_value("link_ready", 32'(link_ready), 32'(0));
                check_value("tx_valid", 32'(tx_valid), 32'(0));
            end
            if (tx_valid) begin
                // All VCs start with credit, so the first pass is in order
                if (total_beats < NUM_VC) begin
                    check_value("tx_vc", 32'(tx_vc), 32'(total_beats));
                end
                check_value($sformatf("tx_seq vc %0d", tx_vc), 32'(tx_seq),
                            32'(beats_on_vc[tx_vc]));
                beats_on_vc[tx_vc]++;
                total_beats++;
                if (beats_on_vc[tx_vc] - fcps_on_vc[tx_vc] > QMAX) begin
                    report_problem($sformatf("More than %0d packets outstanding on VC %0d",
                                             QMAX, tx_vc));
                end
            end
            check_value("tx_count", 32'(tx_count), 32'(total_beats));
            if (fcp_valid) begin
                fcps_on_vc[fcp_vc]++;
                check_value($sformatf("fcp_fccl vc %0d", fcp_vc), 32'(fcp_fccl),
                            32'(fcps_on_vc[fcp_vc] + QMAX));
                if (fcps_on_vc[fcp_vc] > beats_on_vc[fcp_vc]) begin
                    report_problem($sformatf("Credit returned on VC %0d with nothing sent",
                                             fcp_vc));
                end
            end
        end
    end

    // Run limit from the trace length
    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            report_problem($sformatf("Timeout after %0d cycles, the trace did not finish",
                                     cycle_cnt));
        end
    end

    // ==============================
    // Segment replay
    // ==============================
    task automatic run_segments();
        int base;
        for (int seg = 0; seg < num_segs; seg++) begin
            base = seg * SEG_WORDS;
            @(posedge sys_clk);
            link_up    <= trace_mem[base][0];
            drain_hold <= trace_mem[base+1][0];
            repeat (int'(trace_mem[base+2])) @(negedge sys_clk);
            if (trace_mem[base+3] != NO_CHECK) begin
                check_value($sformatf("tx_count at end of segment %0d", seg),
                            32'(tx_count), 32'(trace_mem[base+3]));
            end
            if (trace_mem[base+4] != NO_CHECK) begin
                check_value($sformatf("buffer_used at end of segment %0d", seg),
                            32'(buffer_used), 32'(trace_mem[base+4]));
            end
        end
    endtask

    initial begin
        link_up    = 1'b0;
        drain_hold = 1'b0;
        for (int i = 0; i < MAX_SEGS * SEG_WORDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("tb/link_trace.txt", trace_mem);
        // A zero cycle count ends the trace
        while (num_segs < MAX_SEGS && trace_mem[num_segs*SEG_WORDS+2] != 16'h0000) begin
            cycle_limit += int'(trace_mem[num_segs*SEG_WORDS+2]);
            num_segs++;
        end
        cycle_limit += TIMEOUT_PAD;
        if (num_segs == 0) begin
            report_problem("No segments could be read from tb/link_trace.txt");
        end else begin
            wait (arst_n === 1'b1);
            run_segments();
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/flow_link_assertions.sv ====
// ==============================
// Concurrent checks on the link top-level ports.
// Attached to flow_link_top by the bind at the end of the file.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module flow_link_assertions #(
    parameter int QMAX = 6
) (
    input logic                      sys_clk,
    input logic                      arst_n,
    input logic                      link_ready,
    input logic                      tx_valid,
    input logic                      fcp_valid,
    input logic [fcp_pkg::CNT_W-1:0] buffer_used
);

    import fcp_pkg::*;

    localparam int MAX_USED = NUM_VC * QMAX;

    // A beat is always decided in a cycle with link ready
    tx_after_ready: assert property (@(posedge sys_clk) disable iff (!arst_n)
        tx_valid |-> $past(link_ready))
        else $error("tx_valid high without link_ready on the previous cycle");

    // Credits bound the buffer to the per-VC windows
    buffer_bound: assert property (@(posedge sys_clk) disable iff (!arst_n)
        buffer_used <= CNT_W'(MAX_USED))
        else $error("buffer_used above the total credit window");

    // Credit update only follows a drain from a non-empty buffer
    fcp_after_data: assert property (@(posedge sys_clk) disable iff (!arst_n)
        fcp_valid |-> ($past(buffer_used) != '0))
        else $error("fcp_valid high after a cycle with an empty buffer");

endmodule

bind flow_link_top flow_link_assertions #(
    .QMAX(QMAX)
) u_assertions (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .link_ready (link_ready),
    .tx_valid   (tx_valid),
    .fcp_valid  (fcp_valid),
    .buffer_used(buffer_used)
);

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// ==============================
// Clock and reset source for the testbench.
// sys_clk free-runs; arst_n is held low for RESET_CYCLES.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic sys_clk,
    output logic arst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end

    // Release lines up with a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== logic/flow_link_top.sv ====
// ==============================
// Top level of the credit link.
// Startup control enables the injector; the switch returns
// credits over FCP. All sizing parameters are set here.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module flow_link_top #(
    parameter int QMAX          = 6,
    parameter int DRAIN_RATIO   = 8,
    parameter int STABLE_CYCLES = 64,
    // 2^BUF_ADDR_W must cover NUM_VC * QMAX
    parameter int BUF_ADDR_W    = 7
) (
    input  logic                      sys_clk,
    input  logic                      arst_n,
    input  logic                      link_up,
    input  logic                      drain_hold,
    output logic                      link_ready,
    output logic                      tx_valid,
    output logic [fcp_pkg::VC_W-1:0]  tx_vc,
    output logic [fcp_pkg::CNT_W-1:0] tx_seq,
    output logic [fcp_pkg::CNT_W-1:0] tx_count,
    output logic                      fcp_valid,
    output logic [fcp_pkg::VC_W-1:0]  fcp_vc,
    output logic [fcp_pkg::CNT_W-1:0] fcp_fccl,
    output logic [fcp_pkg::CNT_W-1:0] buffer_used
);

    import fcp_pkg::*;

    fcp_word_u fcp_word;

    // ==============================
    // Control
    // ==============================
    link_startup_ctrl #(
        .STABLE_CYCLES(STABLE_CYCLES)
    ) u_startup (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .link_up   (link_up),
        .link_ready(link_ready)
    );

    // ==============================
    // Datapath
    // ==============================
    credit_injector #(
        .QMAX(QMAX)
    ) u_injector (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .link_ready(link_ready),
        .fcp_valid (fcp_valid),
        .fcp_word  (fcp_word),
        .tx_valid  (tx_valid),
        .tx_vc     (tx_vc),
        .tx_seq    (tx_seq),
        .tx_count  (tx_count)
    );

    downstream_switch #(
        .QMAX       (QMAX),
        .DRAIN_RATIO(DRAIN_RATIO),
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_switch (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .tx_valid   (tx_valid),
        .tx_vc      (tx_vc),
        .drain_hold (drain_hold),
        .fcp_valid  (fcp_valid),
        .fcp_word   (fcp_word),
        .buffer_used(buffer_used)
    );

    // FCP fields brought out for observation
    assign fcp_vc   = fcp_word.fields.vc;
    assign fcp_fccl = fcp_word.fields.fccl;

endmodule

`default_nettype wire

// ==== logic/downstream_switch.sv ====
// ==============================
// Downstream switch model.
// Buffers every arriving beat, drains one packet per
// DRAIN_RATIO cycles and returns a credit update per drain.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module downstream_switch #(
    parameter int QMAX        = 6,
    parameter int DRAIN_RATIO = 8,
    parameter int BUF_ADDR_W  = 7
) (
    input  logic                      sys_clk,
    input  logic                      arst_n,
    input  logic                      tx_valid,
    input  logic [fcp_pkg::VC_W-1:0]  tx_vc,
    input  logic                      drain_hold,
    output logic                      fcp_valid,
    output fcp_pkg::fcp_word_u        fcp_word,
    output logic [fcp_pkg::CNT_W-1:0] buffer_used
);

    import fcp_pkg::*;

    localparam int RATIO_W = (DRAIN_RATIO > 1) ? $clog2(DRAIN_RATIO) : 1;

    logic [RATIO_W-1:0]  ratio_cnt;
    logic                drain_tick;
    logic                pop;
    logic [VC_W-1:0]     pop_vc;
    logic                empty;
    logic [BUF_ADDR_W:0] fifo_count;
    logic [CNT_W-1:0]    drained_cnt [NUM_VC];
    logic [CNT_W-1:0]    drained_next;

    // Every beat is accepted, credits guarantee room
    switch_buffer_fifo #(
        .BUF_ADDR_W(BUF_ADDR_W)
    ) u_buffer (
        .sys_clk(sys_clk),
        .arst_n (arst_n),
        .push   (tx_valid),
        .push_vc(tx_vc),
        .pop    (pop),
        .pop_vc (pop_vc),
        .empty  (empty),
        .count  (fifo_count)
    );

    // ==============================
    // Drain cadence
    // ==============================
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            ratio_cnt <= '0;
        end else if (drain_tick) begin
            ratio_cnt <= '0;
        end else begin
            ratio_cnt <= ratio_cnt + 1'b1;
        end
    end

    assign drain_tick   = (ratio_cnt == RATIO_W'(DRAIN_RATIO - 1));
    assign pop          = drain_tick && !drain_hold && !empty;
    assign drained_next = drained_cnt[pop_vc] + 1'b1;

    // ==============================
    // Credit return
    // ==============================
    // FCP is registered on the pop edge, valid the cycle after
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            fcp_valid <= 1'b0;
            fcp_word  <= '0;
            for (int v = 0; v < NUM_VC; v++) begin
                drained_cnt[v] <= '0;
            end
        end else begin
            fcp_valid <= pop;
            if (pop) begin
                drained_cnt[pop_vc]   <= drained_next;
                fcp_word.fields.vc    <= pop_vc;
                fcp_word.fields.rsvd  <= '0;
                // New limit is drained total plus the per-VC window
                fcp_word.fields.fccl  <= drained_next + CNT_W'(QMAX);
            end
        end
    end

    assign buffer_used = CNT_W'(fifo_count);

endmodule

`default_nettype wire

// ==== logic/credit_injector.sv ====
// ==============================
// Upstream traffic source.
// Sends single-beat packets round-robin over all VCs, each VC
// limited by the credit limit last returned for it over FCP.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module credit_injector #(
    parameter int QMAX = 6
) (
    input  logic                      sys_clk,
    input  logic                      arst_n,
    input  logic                      link_ready,
    input  logic                      fcp_valid,
    input  fcp_pkg::fcp_word_u        fcp_word,
    output logic                      tx_valid,
    output logic [fcp_pkg::VC_W-1:0]  tx_vc,
    output logic [fcp_pkg::CNT_W-1:0] tx_seq,
    output logic [fcp_pkg::CNT_W-1:0] tx_count
);

    import fcp_pkg::*;

    // Per-VC state
    logic [CNT_W-1:0] sent_cnt   [NUM_VC];
    logic [CNT_W-1:0] credit_lim [NUM_VC];

    logic [VC_W-1:0]  last_vc;
    logic [VC_W-1:0]  pick_vc;
    logic             pick_found;
    logic             send;

    // ==============================
    // VC selection
    // ==============================
    // Search starts just after the last VC sent, the last VC
    // itself is checked at the end of the loop
    always_comb begin
        logic [VC_W-1:0] cand;
        pick_found = 1'b0;
        pick_vc    = last_vc;
        for (int i = 1; i <= NUM_VC; i++) begin
            cand = last_vc + VC_W'(i);
            if (!pick_found && (sent_cnt[cand] != credit_lim[cand])) begin
                pick_found = 1'b1;
                pick_vc    = cand;
            end
        end
    end

    assign send = link_ready && pick_found;

    // ==============================
    // Beat register and counters
    // ==============================
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_valid <= 1'b0;
            tx_vc    <= '0;
            tx_seq   <= '0;
            tx_count <= '0;
            // First pick after reset is VC 0
            last_vc  <= VC_W'(NUM_VC - 1);
            for (int v = 0; v < NUM_VC; v++) begin
                sent_cnt[v] <= '0;
            end
        end else begin
            tx_valid <= send;
            if (send) begin
                tx_vc             <= pick_vc;
                // Sequence number is the count before this beat
                tx_seq            <= sent_cnt[pick_vc];
                tx_count          <= tx_count + 1'b1;
                last_vc           <= pick_vc;
                sent_cnt[pick_vc] <= sent_cnt[pick_vc] + 1'b1;
            end
        end
    end

    // ==============================
    // FCP decode
    // ==============================
    // New limit replaces the old one, FCPs for a VC arrive in order
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int v = 0; v < NUM_VC; v++) begin
                credit_lim[v] <= CNT_W'(QMAX);
            end
        end else if (fcp_valid) begin
            credit_lim[fcp_word.fields.vc] <= fcp_word.fields.fccl;
        end
    end

endmodule

`default_nettype wire

// ==== logic/switch_buffer_fifo.sv ====
// ==============================
// Switch packet buffer.
// Circular store of the VC of each buffered packet. Head entry
// is always visible on pop_vc; push and pop may share a cycle.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module switch_buffer_fifo #(
    parameter int BUF_ADDR_W = 7
) (
    input  logic                     sys_clk,
    input  logic                     arst_n,
    input  logic                     push,
    input  logic [fcp_pkg::VC_W-1:0] push_vc,
    input  logic                     pop,
    output logic [fcp_pkg::VC_W-1:0] pop_vc,
    output logic                     empty,
    output logic [BUF_ADDR_W:0]      count
);

    import fcp_pkg::*;

    localparam int DEPTH = 1 << BUF_ADDR_W;

    logic [VC_W-1:0]       mem [DEPTH];
    logic [BUF_ADDR_W-1:0] wr_ptr;
    logic [BUF_ADDR_W-1:0] rd_ptr;

    // Storage
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_vc;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign pop_vc = mem[rd_ptr];
    assign empty  = (count == '0);

endmodule

`default_nettype wire

// ==== logic/link_startup_ctrl.sv ====
// ==============================
// Safe startup for the link.
// Synchronizes link_up and raises link_ready only after the
// status has stayed high for STABLE_CYCLES cycles.
// ==============================

`timescale 1ns/100ps
`default_nettype none

module link_startup_ctrl #(
    parameter int STABLE_CYCLES = 64
) (
    input  logic sys_clk,
    input  logic arst_n,
    input  logic link_up,
    output logic link_ready
);

    localparam int STAB_W = $clog2(STABLE_CYCLES + 1);

    logic              sync_q1;
    logic              sync_q2;
    logic [STAB_W-1:0] stable_cnt;

    // Two-flop synchronizer on the raw status
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= link_up;
            sync_q2 <= sync_q1;
        end
    end

    // Stability counter, restarts on any drop of the synced status
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            stable_cnt <= '0;
            link_ready <= 1'b0;
        end else if (!sync_q2) begin
            stable_cnt <= '0;
            link_ready <= 1'b0;
        end else if (stable_cnt == STAB_W'(STABLE_CYCLES)) begin
            link_ready <= 1'b1;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fcp_pkg.sv ====
// ==============================
// Shared widths and the FCP word for the credit link.
// Import into module bodies; port headers use scoped names.
// ==============================

`default_nettype none

package fcp_pkg;

    // ==============================
    // Widths
    // ==============================
    // VC number width, 16 VCs
    localparam int VC_W   = 4;
    localparam int NUM_VC = 1 << VC_W;

    // Sequence numbers, credit limits and debug counters
    // Wrap modulo 2^16, compare by difference only
    localparam int CNT_W  = 16;

    // Return path word
    localparam int FCP_W  = 32;

    // ==============================
    // FCP word
    // ==============================
    // Built field by field in the switch, carried raw,
    // split again on the injector side
    typedef union packed {
        logic [FCP_W-1:0] raw;
        struct packed {
            logic [VC_W-1:0]             vc;
            logic [FCP_W-VC_W-CNT_W-1:0] rsvd;
            logic [CNT_W-1:0]            fccl;
        } fields;
    } fcp_word_u;

endpackage

`default_nettype wire
